//--- include/decode_macros.svh
// ------------------------------------------------------------------
// Width macros shared by the RV32I decode stage
// The immediate builder assumes DEC_XLEN and DEC_ILEN are both 32
// ------------------------------------------------------------------
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Data path and PC width
`define DEC_XLEN 32

`define DEC_REG_AW 5    // Register file address bits
`define DEC_ILEN 32     // Uncompressed encodings only

`endif

//--- rtl/isa_pkg.sv
// ------------------------------------------------------------------
// RV32I encoding fields seen by the decoder
// Only the major opcodes kept by this stage are listed
// ------------------------------------------------------------------
`default_nettype none

package isa_pkg;

    // Major opcode, instruction bits 6:0
    typedef enum logic [6:0] {
        OPCODE_OP     = 7'b0110011,
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_LOAD   = 7'b0000011,
        OPCODE_STORE  = 7'b0100011,
        OPCODE_BRANCH = 7'b1100011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111   // 010 and 011 are reserved
    } br_funct3_e;

endpackage

`default_nettype wire

//--- rtl/uop_pkg.sv
// ------------------------------------------------------------------
// Micro-ops and operand selects passed from decode to execute
// Value 0 of every op is a NOP so a cleared register is a bubble
// ------------------------------------------------------------------
`default_nettype none

package uop_pkg;

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND
    } alu_op_e;

    typedef enum logic [3:0] {
        LSU_NOP, LSU_LB, LSU_LBU, LSU_LH, LSU_LHU, LSU_LW,
        LSU_SB,  LSU_SH, LSU_SW
    } lsu_op_e;

    // Conditional branches, plus JAL for both jump forms
    typedef enum logic [2:0] {
        CFU_NOP, CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU, CFU_JAL
    } cfu_op_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_SHAMT, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef enum logic [1:0] {OPA_ZERO, OPA_RS1, OPA_PC} opr_a_sel_e;
    typedef enum logic [1:0] {OPB_ZERO, OPB_RS2, OPB_IMM} opr_b_sel_e;
    typedef enum logic [1:0] {OPC_ZERO, OPC_RS2, OPC_IMM, OPC_NPC} opr_c_sel_e;

endpackage

`default_nettype wire

//--- rtl/imm_gen.sv
// ------------------------------------------------------------------
// Immediate builder for the 32-bit RISC-V formats
// SHAMT is zero-extended, NONE gives zero, the rest sign-extend
// ------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module imm_gen (
    input  wire logic [`DEC_ILEN-1:0] instr_i,
    input  wire uop_pkg::imm_fmt_e    fmt_i,
    output logic      [`DEC_XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];     // Sign bit sits at 31 in every format

    always_comb begin
        case (fmt_i)
            uop_pkg::IMM_I:
                imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[31:20]};
            uop_pkg::IMM_SHAMT:
                imm_o = {{(`DEC_XLEN-5){1'b0}}, instr_i[24:20]};
            uop_pkg::IMM_S:
                imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            // Branch offset, halfword aligned
            uop_pkg::IMM_B:
                imm_o = {{(`DEC_XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            uop_pkg::IMM_U:
                imm_o = {instr_i[31:12], 12'b0};    // Upper 20 bits
            uop_pkg::IMM_J:
                imm_o = {{(`DEC_XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_decoder.sv
// ------------------------------------------------------------------
// RV32I decoder, one major opcode per case arm
// Unknown opcodes, FENCE included, decode to an all-NOP bubble
// Reserved funct3 values inside a known group give a NOP op
// ------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module instr_decoder (
    input  wire logic [`DEC_ILEN-1:0]   instr_i,
    output uop_pkg::alu_op_e            alu_op_o,
    output uop_pkg::lsu_op_e            lsu_op_o,
    output uop_pkg::cfu_op_e            cfu_op_o,
    output uop_pkg::imm_fmt_e           imm_fmt_o,
    output uop_pkg::opr_a_sel_e         opr_a_sel_o,
    output uop_pkg::opr_b_sel_e         opr_b_sel_o,
    output uop_pkg::opr_c_sel_e         opr_c_sel_o,
    output logic      [`DEC_REG_AW-1:0] rd_o
);

    // ALU op for OP and OP_IMM, alt picks SUB or SRA
    function automatic uop_pkg::alu_op_e alu_from_funct3(logic [2:0] f3, logic alt);
        case (f3)
            3'b000:  return alt ? uop_pkg::ALU_SUB : uop_pkg::ALU_ADD;
            3'b001:  return uop_pkg::ALU_SLL;
            3'b010:  return uop_pkg::ALU_SLT;
            3'b011:  return uop_pkg::ALU_SLTU;
            3'b100:  return uop_pkg::ALU_XOR;
            3'b101:  return alt ? uop_pkg::ALU_SRA : uop_pkg::ALU_SRL;
            3'b110:  return uop_pkg::ALU_OR;
            default: return uop_pkg::ALU_AND;
        endcase
    endfunction

    logic [2:0] funct3;
    logic       is_shift;

    assign funct3   = instr_i[14:12];
    assign is_shift = (funct3[1:0] == 2'b01);   // SLLI or SRLI/SRAI

    always_comb begin
        alu_op_o    = uop_pkg::ALU_NOP;
        lsu_op_o    = uop_pkg::LSU_NOP;
        cfu_op_o    = uop_pkg::CFU_NOP;
        imm_fmt_o   = uop_pkg::IMM_NONE;
        opr_a_sel_o = uop_pkg::OPA_ZERO;
        opr_b_sel_o = uop_pkg::OPB_ZERO;
        opr_c_sel_o = uop_pkg::OPC_ZERO;
        rd_o        = '0;

        case (isa_pkg::opcode_e'(instr_i[6:0]))
            isa_pkg::OPCODE_OP: begin
                alu_op_o    = alu_from_funct3(funct3, instr_i[30]);
                opr_a_sel_o = uop_pkg::OPA_RS1;
                opr_b_sel_o = uop_pkg::OPB_RS2;
                rd_o        = instr_i[11:7];
            end
            isa_pkg::OPCODE_OP_IMM: begin
                // Bit 30 only means SRAI, ADDI has no SUB form
                alu_op_o    = alu_from_funct3(funct3, instr_i[30] && funct3 == 3'b101);
                imm_fmt_o   = is_shift ? uop_pkg::IMM_SHAMT : uop_pkg::IMM_I;
                opr_a_sel_o = uop_pkg::OPA_RS1;
                opr_b_sel_o = uop_pkg::OPB_IMM;
                rd_o        = instr_i[11:7];
            end
            isa_pkg::OPCODE_LOAD: begin
                alu_op_o    = uop_pkg::ALU_ADD;     // Address = rs1 + imm
                case (funct3)
                    3'b000:  lsu_op_o = uop_pkg::LSU_LB;
                    3'b001:  lsu_op_o = uop_pkg::LSU_LH;
                    3'b010:  lsu_op_o = uop_pkg::LSU_LW;
                    3'b100:  lsu_op_o = uop_pkg::LSU_LBU;
                    3'b101:  lsu_op_o = uop_pkg::LSU_LHU;
                    default: lsu_op_o = uop_pkg::LSU_NOP;
                endcase
                imm_fmt_o   = uop_pkg::IMM_I;
                opr_a_sel_o = uop_pkg::OPA_RS1;
                opr_b_sel_o = uop_pkg::OPB_IMM;
                rd_o        = instr_i[11:7];
            end
            isa_pkg::OPCODE_STORE: begin
                alu_op_o    = uop_pkg::ALU_ADD;
                case (funct3)
                    3'b000:  lsu_op_o = uop_pkg::LSU_SB;
                    3'b001:  lsu_op_o = uop_pkg::LSU_SH;
                    3'b010:  lsu_op_o = uop_pkg::LSU_SW;
                    default: lsu_op_o = uop_pkg::LSU_NOP;
                endcase
                imm_fmt_o   = uop_pkg::IMM_S;
                opr_a_sel_o = uop_pkg::OPA_RS1;
                opr_b_sel_o = uop_pkg::OPB_IMM;
                opr_c_sel_o = uop_pkg::OPC_RS2;     // Store data rides on C
            end
            isa_pkg::OPCODE_BRANCH: begin
                alu_op_o    = uop_pkg::ALU_SUB;     // Compare rs1 against rs2
                case (isa_pkg::br_funct3_e'(funct3))
                    isa_pkg::BR_BEQ:  cfu_op_o = uop_pkg::CFU_BEQ;
                    isa_pkg::BR_BNE:  cfu_op_o = uop_pkg::CFU_BNE;
                    isa_pkg::BR_BLT:  cfu_op_o = uop_pkg::CFU_BLT;
                    isa_pkg::BR_BGE:  cfu_op_o = uop_pkg::CFU_BGE;
                    isa_pkg::BR_BLTU: cfu_op_o = uop_pkg::CFU_BLTU;
                    isa_pkg::BR_BGEU: cfu_op_o = uop_pkg::CFU_BGEU;
                    default:          cfu_op_o = uop_pkg::CFU_NOP;
                endcase
                imm_fmt_o   = uop_pkg::IMM_B;
                opr_a_sel_o = uop_pkg::OPA_RS1;
                opr_b_sel_o = uop_pkg::OPB_RS2;
                opr_c_sel_o = uop_pkg::OPC_IMM;     // Offset goes to C
            end
            isa_pkg::OPCODE_JAL, isa_pkg::OPCODE_JALR: begin
                cfu_op_o    = uop_pkg::CFU_JAL;
                imm_fmt_o   = instr_i[3] ? uop_pkg::IMM_J : uop_pkg::IMM_I;
                opr_a_sel_o = instr_i[3] ? uop_pkg::OPA_PC : uop_pkg::OPA_RS1;
                opr_b_sel_o = uop_pkg::OPB_IMM;
                opr_c_sel_o = uop_pkg::OPC_NPC;     // Link value
                rd_o        = instr_i[11:7];
            end
            isa_pkg::OPCODE_LUI, isa_pkg::OPCODE_AUIPC: begin
                // LUI is 0 | imm, AUIPC is pc + imm
                alu_op_o    = instr_i[5] ? uop_pkg::ALU_OR : uop_pkg::ALU_ADD;
                imm_fmt_o   = uop_pkg::IMM_U;
                opr_a_sel_o = instr_i[5] ? uop_pkg::OPA_ZERO : uop_pkg::OPA_PC;
                opr_b_sel_o = uop_pkg::OPB_IMM;
                rd_o        = instr_i[11:7];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/operand_select.sv
// ------------------------------------------------------------------
// Operand multiplexers for the execute stage
// NPC is always PC + 4 since compressed encodings are not supported
// ------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module operand_select (
    input  wire uop_pkg::opr_a_sel_e  opr_a_sel_i,
    input  wire uop_pkg::opr_b_sel_e  opr_b_sel_i,
    input  wire uop_pkg::opr_c_sel_e  opr_c_sel_i,
    input  wire logic [`DEC_XLEN-1:0] rs1_data_i,
    input  wire logic [`DEC_XLEN-1:0] rs2_data_i,
    input  wire logic [`DEC_XLEN-1:0] pc_i,
    input  wire logic [`DEC_XLEN-1:0] imm_i,
    output logic      [`DEC_XLEN-1:0] opr_a_o,
    output logic      [`DEC_XLEN-1:0] opr_b_o,
    output logic      [`DEC_XLEN-1:0] opr_c_o
);

    logic [`DEC_XLEN-1:0] npc;

    assign npc = pc_i + `DEC_XLEN'(4);      // Return address for jumps

    // ------------------------------------------------------------------
    // Operand A and B
    // ------------------------------------------------------------------

    always_comb begin
        case (opr_a_sel_i)
            uop_pkg::OPA_RS1: opr_a_o = rs1_data_i;
            uop_pkg::OPA_PC:  opr_a_o = pc_i;
            default:          opr_a_o = '0;
        endcase
    end

    always_comb begin
        case (opr_b_sel_i)
            uop_pkg::OPB_RS2: opr_b_o = rs2_data_i;
            uop_pkg::OPB_IMM: opr_b_o = imm_i;
            default:          opr_b_o = '0;
        endcase
    end

    // Operand C carries store data, branch offset or link address
    always_comb begin
        case (opr_c_sel_i)
            uop_pkg::OPC_RS2: opr_c_o = rs2_data_i;
            uop_pkg::OPC_IMM: opr_c_o = imm_i;
            uop_pkg::OPC_NPC: opr_c_o = npc;
            default:          opr_c_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/decode_ex_reg.sv
// ------------------------------------------------------------------
// Single-entry decode to execute register with valid/ready
// Flush wins over a new accept, reset and flush zero every field
// Refills on the edge the old entry leaves, one item per cycle
// ------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module decode_ex_reg (
    input  wire logic                   g_clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   flush_i,
    input  wire logic                   in_valid_i,
    input  wire logic                   out_ready_i,
    output logic                        in_ready_o,
    output logic                        out_valid_o,
    input  wire logic [`DEC_XLEN-1:0]   pc_i,
    input  wire logic [`DEC_XLEN-1:0]   opr_a_i,
    input  wire logic [`DEC_XLEN-1:0]   opr_b_i,
    input  wire logic [`DEC_XLEN-1:0]   opr_c_i,
    input  wire logic [`DEC_REG_AW-1:0] rd_i,
    input  wire uop_pkg::alu_op_e       alu_op_i,
    input  wire uop_pkg::lsu_op_e       lsu_op_i,
    input  wire uop_pkg::cfu_op_e       cfu_op_i,
    input  wire logic [`DEC_ILEN-1:0]   instr_i,
    output logic      [`DEC_XLEN-1:0]   pc_o,
    output logic      [`DEC_XLEN-1:0]   opr_a_o,
    output logic      [`DEC_XLEN-1:0]   opr_b_o,
    output logic      [`DEC_XLEN-1:0]   opr_c_o,
    output logic      [`DEC_REG_AW-1:0] rd_o,
    output uop_pkg::alu_op_e            alu_op_o,
    output uop_pkg::lsu_op_e            lsu_op_o,
    output uop_pkg::cfu_op_e            cfu_op_o,
    output logic      [`DEC_ILEN-1:0]   instr_o
);

    logic accept;

    // Free when empty or when the held entry leaves this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge g_clk) begin
        if (!rst_n_i || flush_i) begin
            out_valid_o <= 1'b0;
            pc_o        <= '0;
            opr_a_o     <= '0;
            opr_b_o     <= '0;
            opr_c_o     <= '0;
            rd_o        <= '0;
            alu_op_o    <= uop_pkg::ALU_NOP;
            lsu_op_o    <= uop_pkg::LSU_NOP;
            cfu_op_o    <= uop_pkg::CFU_NOP;
            instr_o     <= '0;
        end else begin
            if (in_ready_o) begin
                out_valid_o <= in_valid_i;  // Drains when nothing arrives
            end
            if (accept) begin
                pc_o     <= pc_i;
                opr_a_o  <= opr_a_i;
                opr_b_o  <= opr_b_i;
                opr_c_o  <= opr_c_i;
                rd_o     <= rd_i;
                alu_op_o <= alu_op_i;
                lsu_op_o <= lsu_op_i;
                cfu_op_o <= cfu_op_i;
                instr_o  <= instr_i;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
// ------------------------------------------------------------------
// RV32I decode and operand gather stage, top level
// Register file read is combinational in the accepting cycle
// ------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module decode_stage (
    input  wire logic                   g_clk,
    input  wire logic                   rst_n_i,
    input  wire logic                   s1_valid_i,
    input  wire logic [`DEC_ILEN-1:0]   s1_instr_i,
    input  wire logic [`DEC_XLEN-1:0]   s1_pc_i,
    output logic                        s1_ready_o,
    input  wire logic                   s1_flush_i,
    output logic      [`DEC_REG_AW-1:0] rs1_addr_o,
    input  wire logic [`DEC_XLEN-1:0]   rs1_data_i,
    output logic      [`DEC_REG_AW-1:0] rs2_addr_o,
    input  wire logic [`DEC_XLEN-1:0]   rs2_data_i,
    output logic                        s2_valid_o,
    input  wire logic                   s2_ready_i,
    output logic      [`DEC_XLEN-1:0]   s2_pc_o,
    output logic      [`DEC_XLEN-1:0]   s2_opr_a_o,
    output logic      [`DEC_XLEN-1:0]   s2_opr_b_o,
    output logic      [`DEC_XLEN-1:0]   s2_opr_c_o,
    output logic      [`DEC_REG_AW-1:0] s2_rd_o,
    output uop_pkg::alu_op_e            s2_alu_op_o,
    output uop_pkg::lsu_op_e            s2_lsu_op_o,
    output uop_pkg::cfu_op_e            s2_cfu_op_o,
    output logic      [`DEC_ILEN-1:0]   s2_instr_o
);

    uop_pkg::alu_op_e     alu_op;
    uop_pkg::lsu_op_e     lsu_op;
    uop_pkg::cfu_op_e     cfu_op;
    uop_pkg::imm_fmt_e    imm_fmt;
    uop_pkg::opr_a_sel_e  opr_a_sel;
    uop_pkg::opr_b_sel_e  opr_b_sel;
    uop_pkg::opr_c_sel_e  opr_c_sel;
    logic [`DEC_REG_AW-1:0] rd;
    logic [`DEC_XLEN-1:0] imm;
    logic [`DEC_XLEN-1:0] opr_a;
    logic [`DEC_XLEN-1:0] opr_b;
    logic [`DEC_XLEN-1:0] opr_c;

    // Source fields sit at fixed positions in every format
    assign rs1_addr_o = s1_instr_i[19:15];
    assign rs2_addr_o = s1_instr_i[24:20];

    instr_decoder u_decoder (
        .instr_i     (s1_instr_i),
        .alu_op_o    (alu_op),
        .lsu_op_o    (lsu_op),
        .cfu_op_o    (cfu_op),
        .imm_fmt_o   (imm_fmt),
        .opr_a_sel_o (opr_a_sel),
        .opr_b_sel_o (opr_b_sel),
        .opr_c_sel_o (opr_c_sel),
        .rd_o        (rd)
    );

    imm_gen u_imm_gen (
        .instr_i (s1_instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    operand_select u_opr_sel (
        .opr_a_sel_i (opr_a_sel),
        .opr_b_sel_i (opr_b_sel),
        .opr_c_sel_i (opr_c_sel),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .pc_i        (s1_pc_i),
        .imm_i       (imm),
        .opr_a_o     (opr_a),
        .opr_b_o     (opr_b),
        .opr_c_o     (opr_c)
    );

    // ------------------------------------------------------------------
    // Decode to execute register
    // ------------------------------------------------------------------

    decode_ex_reg u_ex_reg (
        .g_clk       (g_clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (s1_flush_i),
        .in_valid_i  (s1_valid_i),
        .out_ready_i (s2_ready_i),
        .in_ready_o  (s1_ready_o),
        .out_valid_o (s2_valid_o),
        .pc_i        (s1_pc_i),
        .opr_a_i     (opr_a),
        .opr_b_i     (opr_b),
        .opr_c_i     (opr_c),
        .rd_i        (rd),
        .alu_op_i    (alu_op),
        .lsu_op_i    (lsu_op),
        .cfu_op_i    (cfu_op),
        .instr_i     (s1_instr_i),
        .pc_o        (s2_pc_o),
        .opr_a_o     (s2_opr_a_o),
        .opr_b_o     (s2_opr_b_o),
        .opr_c_o     (s2_opr_c_o),
        .rd_o        (s2_rd_o),
        .alu_op_o    (s2_alu_op_o),
        .lsu_op_o    (s2_lsu_op_o),
        .cfu_op_o    (s2_cfu_op_o),
        .instr_o     (s2_instr_o)
    );

endmodule

`default_nettype wire

//--- tb/decode_asserts.sv
// ----------------------------------------------------------------------
// Handshake properties of the decode to execute register
// Bound into every decode_stage instance
// ----------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module decode_asserts (
    input wire logic                   g_clk,
    input wire logic                   rst_n_i,
    input wire logic                   flush_i,
    input wire logic                   valid_i,
    input wire logic                   ready_i,
    input wire logic [`DEC_XLEN-1:0]   pc_i,
    input wire logic [`DEC_XLEN-1:0]   opr_a_i,
    input wire logic [`DEC_XLEN-1:0]   opr_b_i,
    input wire logic [`DEC_XLEN-1:0]   opr_c_i,
    input wire logic [`DEC_REG_AW-1:0] rd_i,
    input wire uop_pkg::alu_op_e       alu_op_i,
    input wire uop_pkg::lsu_op_e       lsu_op_i,
    input wire uop_pkg::cfu_op_e       cfu_op_i,
    input wire logic [`DEC_ILEN-1:0]   instr_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Register is empty right after a reset edge
    a_reset_empty: assert property (@(posedge g_clk) !rst_n_i |=> !valid_i)
        else $error("s2_valid_o high after reset");

    // Held entry must not change while execute stalls
    a_stall_stable: assert property (@(posedge g_clk) disable iff (!rst_n_i)
        (valid_i && !ready_i && !flush_i) |=>
            (valid_i && $stable(pc_i) && $stable(opr_a_i) && $stable(opr_b_i)
             && $stable(opr_c_i) && $stable(rd_i) && $stable(alu_op_i)
             && $stable(lsu_op_i) && $stable(cfu_op_i) && $stable(instr_i)))
        else $error("s2 outputs changed during a stall");

    a_flush_empty: assert property (@(posedge g_clk) (rst_n_i && flush_i) |=> !valid_i)
        else $error("s2_valid_o high after a flush");

endmodule

bind decode_stage decode_asserts u_asserts (
    .g_clk    (g_clk),
    .rst_n_i  (rst_n_i),
    .flush_i  (s1_flush_i),
    .valid_i  (s2_valid_o),
    .ready_i  (s2_ready_i),
    .pc_i     (s2_pc_o),
    .opr_a_i  (s2_opr_a_o),
    .opr_b_i  (s2_opr_b_o),
    .opr_c_i  (s2_opr_c_o),
    .rd_i     (s2_rd_o),
    .alu_op_i (s2_alu_op_o),
    .lsu_op_i (s2_lsu_op_o),
    .cfu_op_i (s2_cfu_op_o),
    .instr_i  (s2_instr_o)
);

`default_nettype wire

//--- tb/tb_decode_stage.sv
// ----------------------------------------------------------------------
// Testbench for the decode stage, replays the stimulus vectors
// Run from the project root so the data file path resolves
// ----------------------------------------------------------------------
`default_nettype none

`include "decode_macros.svh"

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_VEC    = 20;
    localparam int NUM_FIELD  = 9;
    localparam int WAIT_LIMIT = 50;                 // Cycles per wait
    localparam int F_INSTR = 0, F_PC = 1, F_ALU = 2, F_LSU = 3, F_CFU = 4;
    localparam int F_RD = 5, F_A = 6, F_B = 7, F_C = 8;

    logic                    g_clk = 1'b0;
    logic                    rst_n_i;
    logic                    s1_valid_i;
    logic [`DEC_ILEN-1:0]    s1_instr_i;
    logic [`DEC_XLEN-1:0]    s1_pc_i;
    logic                    s1_ready_o;
    logic                    s1_flush_i;
    logic [`DEC_REG_AW-1:0]  rs1_addr_o;
    logic [`DEC_REG_AW-1:0]  rs2_addr_o;
    logic [`DEC_XLEN-1:0]    rs1_data_i;
    logic [`DEC_XLEN-1:0]    rs2_data_i;
    logic                    s2_valid_o;
    logic                    s2_ready_i;
    logic [`DEC_XLEN-1:0]    s2_pc_o;
    logic [`DEC_XLEN-1:0]    s2_opr_a_o;
    logic [`DEC_XLEN-1:0]    s2_opr_b_o;
    logic [`DEC_XLEN-1:0]    s2_opr_c_o;
    logic [`DEC_REG_AW-1:0]  s2_rd_o;
    uop_pkg::alu_op_e        s2_alu_op_o;
    uop_pkg::lsu_op_e        s2_lsu_op_o;
    uop_pkg::cfu_op_e        s2_cfu_op_o;
    logic [`DEC_ILEN-1:0]    s2_instr_o;

    logic [31:0] vec_mem [0:NUM_VEC*NUM_FIELD-1];
    integer      seed;

    always #20 g_clk = ~g_clk;

    // Register file model, x[n] reads as base + 16*n
    assign rs1_data_i = 32'h1000_0000 + {23'b0, rs1_addr_o, 4'b0};
    assign rs2_data_i = 32'h1000_0000 + {23'b0, rs2_addr_o, 4'b0};

    decode_stage uut (.*);

    function automatic logic [31:0] vec_word(input int v, input int f);
        return vec_mem[v*NUM_FIELD + f];
    endfunction

    task automatic stop_on_error;
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_on_error();
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_vector(input int v);
        check_value(s2_pc_o, vec_word(v, F_PC), $sformatf("vector %0d pc", v));
        check_value(s2_instr_o, vec_word(v, F_INSTR), $sformatf("vector %0d instr", v));
        check_value(32'(s2_alu_op_o), vec_word(v, F_ALU), $sformatf("vector %0d alu_op", v));
        check_value(32'(s2_lsu_op_o), vec_word(v, F_LSU), $sformatf("vector %0d lsu_op", v));
        check_value(32'(s2_cfu_op_o), vec_word(v, F_CFU), $sformatf("vector %0d cfu_op", v));
        check_value(32'(s2_rd_o), vec_word(v, F_RD), $sformatf("vector %0d rd", v));
        check_value(s2_opr_a_o, vec_word(v, F_A), $sformatf("vector %0d operand A", v));
        check_value(s2_opr_b_o, vec_word(v, F_B), $sformatf("vector %0d operand B", v));
        check_value(s2_opr_c_o, vec_word(v, F_C), $sformatf("vector %0d operand C", v));
    endtask

    task automatic wait_for_valid(input string what);
        int waited;
        waited = 0;
        @(negedge g_clk);
        while (!s2_valid_o) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run({"s2_valid_o never rose ", what});
            @(negedge g_clk);
        end
    endtask

    // ----------------------------------------------------------------------
    // Vector replay, optionally with random execute stalls
    // ----------------------------------------------------------------------
    task automatic stream_vectors(input logic with_stalls);
        int          sent;
        int          rcvd;
        int          cycles;
        int          acc_idx;
        logic        was_accept;
        logic        was_stall;
        logic [31:0] held_pc;
        logic [31:0] held_a;
        logic [31:0] held_c;
        sent = 0;
        rcvd = 0;
        cycles = 0;
        acc_idx = 0;
        was_accept = 1'b0;
        was_stall = 1'b0;
        held_pc = '0;
        held_a = '0;
        held_c = '0;
        while (rcvd < NUM_VEC) begin
            cycles++;
            if (cycles > NUM_VEC * 8) abort_run("vectors did not drain from the stage");
            @(posedge g_clk);
            s1_valid_i <= (sent < NUM_VEC);
            s1_instr_i <= (sent < NUM_VEC) ? vec_word(sent, F_INSTR) : '0;
            s1_pc_i    <= (sent < NUM_VEC) ? vec_word(sent, F_PC) : '0;
            s2_ready_i <= with_stalls ? ($random(seed) % 3 != 0) : 1'b1;
            @(negedge g_clk);
            if (was_accept) begin           // One cycle after the accepting edge
                check_value(32'(s2_valid_o), 1, "valid one cycle after accept");
                check_value(s2_pc_o, vec_word(acc_idx, F_PC), "pc one cycle after accept");
            end
            if (was_stall) begin
                check_value(32'(s2_valid_o), 1, "valid held during stall");
                check_value(s2_pc_o, held_pc, "pc held during stall");
                check_value(s2_opr_a_o, held_a, "operand A held during stall");
                check_value(s2_opr_c_o, held_c, "operand C held during stall");
            end
            was_stall = s2_valid_o && !s2_ready_i;
            if (was_stall) begin
                check_value(32'(s1_ready_o), 0, "s1_ready_o during stall");
                held_pc = s2_pc_o;
                held_a = s2_opr_a_o;
                held_c = s2_opr_c_o;
            end
            if (s2_valid_o && s2_ready_i) begin
                check_vector(rcvd);
                rcvd++;
            end
            was_accept = s1_valid_i && s1_ready_o;
            if (was_accept) begin
                acc_idx = sent;
                sent++;
            end
        end
        if (!with_stalls) check_value(cycles, NUM_VEC + 1, "cycles for back-to-back stream");
        @(posedge g_clk);
        s1_valid_i <= 1'b0;
        s2_ready_i <= 1'b1;
        @(negedge g_clk);
        check_value(32'(s2_valid_o), 0, "valid after the last vector");
    endtask

    task automatic send_and_check(input int v);
        int waited;
        waited = 0;
        @(posedge g_clk);
        s1_valid_i <= 1'b1;
        s1_instr_i <= vec_word(v, F_INSTR);
        s1_pc_i    <= vec_word(v, F_PC);
        s2_ready_i <= 1'b1;
        @(negedge g_clk);
        while (!s1_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) abort_run("s1_ready_o never rose");
            @(negedge g_clk);
        end
        @(posedge g_clk);
        s1_valid_i <= 1'b0;
        wait_for_valid("for a single vector");
        check_vector(v);
    endtask

    // Flush drops a stalled entry and blocks a same-cycle accept
    task automatic flush_check;
        @(posedge g_clk);
        s1_valid_i <= 1'b1;
        s1_instr_i <= vec_word(0, F_INSTR);
        s1_pc_i    <= vec_word(0, F_PC);
        s2_ready_i <= 1'b0;
        @(posedge g_clk);
        s1_valid_i <= 1'b0;
        wait_for_valid("before the flush");
        @(posedge g_clk);
        s1_flush_i <= 1'b1;
        s1_valid_i <= 1'b1;
        s1_instr_i <= vec_word(2, F_INSTR);
        s1_pc_i    <= vec_word(2, F_PC);
        s2_ready_i <= 1'b1;
        @(posedge g_clk);
        s1_flush_i <= 1'b0;
        s1_valid_i <= 1'b0;
        @(negedge g_clk);
        check_value(32'(s2_valid_o), 0, "valid after flush");
        check_value(s2_pc_o, 0, "pc after flush");
        send_and_check(1);
    endtask

    initial begin
        seed       = 32'ha13;
        rst_n_i    = 1'b0;
        s1_valid_i = 1'b0;
        s1_instr_i = '0;
        s1_pc_i    = '0;
        s1_flush_i = 1'b0;
        s2_ready_i = 1'b1;
        $readmemh("tb/decode_stimulus.txt", vec_mem);
        repeat (10) @(posedge g_clk);
        rst_n_i <= 1'b1;
        @(negedge g_clk);
        check_value(32'(s2_valid_o), 0, "s2_valid_o after reset");
        check_value(32'(s1_ready_o), 1, "s1_ready_o after reset");
        check_value(s2_opr_a_o, 0, "operand A after reset");

        stream_vectors(1'b0);       // Full rate
        stream_vectors(1'b1);       // Random back-pressure
        flush_check();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
rtl/isa_pkg.sv
rtl/uop_pkg.sv
rtl/imm_gen.sv
rtl/instr_decoder.sv
rtl/operand_select.sv
rtl/decode_ex_reg.sv
rtl/decode_stage.sv
tb/decode_asserts.sv
tb/tb_decode_stage.sv

//--- Makefile
# Verilator build and run for the RV32I decode stage

TOP = tb_decode_stage

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

//--- tb/decode_stimulus.txt
// instr    pc       alu      lsu      cfu      rd       opr_a    opr_b    opr_c
// register model: x[n] reads as 10000000 + 16*n
002081b3 00001000 00000001 00000000 00000000 00000003 10000010 10000020 00000000
407302b3 00001004 00000002 00000000 00000000 00000005 10000060 10000070 00000000
fff10093 00001008 00000001 00000000 00000000 00000001 10000020 ffffffff 00000000
00329213 0000100c 00000003 00000000 00000000 00000004 10000050 00000003 00000000
41f3d313 00001010 00000008 00000000 00000000 00000006 10000070 0000001f 00000000
7ff4c413 00001014 00000006 00000000 00000000 00000008 10000090 000007ff 00000000
00812503 00001018 00000001 00000005 00000000 0000000a 10000020 00000008 00000000
ffc1c583 0000101c 00000001 00000002 00000000 0000000b 10000030 fffffffc 00000000
0050a623 00001020 00000001 00000008 00000000 00000000 10000010 0000000c 10000050
fe721f23 00001024 00000001 00000007 00000000 00000000 10000040 fffffffe 10000070
00208863 00001028 00000002 00000000 00000001 00000000 10000010 10000020 00000010
fe41ece3 0000102c 00000002 00000000 00000005 00000000 10000030 10000040 fffffff8
0262d063 00001030 00000002 00000000 00000004 00000000 10000050 10000060 00000020
001000ef 00001034 00000000 00000000 00000007 00000001 00001034 00000800 00001038
00008067 00001038 00000000 00000000 00000007 00000000 10000010 00000000 0000103c
123452b7 0000103c 00000009 00000000 00000000 00000005 00000000 12345000 00000000
fffff317 00001040 00000001 00000000 00000000 00000006 00001040 fffff000 00000000
0ff0000f 00001044 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00d777b3 00001048 0000000a 00000000 00000000 0000000f 100000e0 100000d0 00000000
01df3fb3 0000104c 00000005 00000000 00000000 0000001f 100001e0 100001d0 00000000
